/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := cache_tb
FILELIST  := sim.f
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := ** FAIL **

BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -qF '$(FAIL_MSG)' $(LOG); then \
	   echo "Simulation failed, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* hw/cache_back_end.sv */
module cache_back_end (
   input  logic                      clk,
   input  logic                      reset,
   cache_wr_if.sink                  wr,
   cache_refill_if.sink              refill,
   output logic                      mem_req,
   output cache_cfg_pkg::word_addr_t mem_addr,
   output cache_bus_pkg::data_t      mem_wdata,
   output cache_bus_pkg::strb_t      mem_wstrb,
   input  cache_bus_pkg::data_t      mem_rdata,
   input  logic                      mem_ack
);

   typedef enum logic [1:0] {IDLE, WRITE_GNT, REFILL_GNT} state_t;

   state_t state;

   // Fixed priority, the write channel first
   always_ff @(posedge clk) begin
      if (reset) begin
         state <= IDLE;
      end else begin
         case (state)
            IDLE: begin
               if (wr.req) begin
                  state <= WRITE_GNT;
               end else if (refill.req) begin
                  state <= REFILL_GNT;
               end
            end
            default: begin
               if (mem_ack) state <= IDLE;   // Bus free again next cycle
            end
         endcase
      end
   end

   // Bus fields latched at grant, held until mem_ack
   always_ff @(posedge clk) begin
      if (state == IDLE) begin
         if (wr.req) begin
            mem_addr  <= wr.addr;
            mem_wdata <= wr.wdata;
            mem_wstrb <= wr.wstrb;
         end else begin
            mem_addr  <= {refill.line, refill.offset};   // Word address of the fill
            mem_wstrb <= '0;                             // Read
         end
      end
   end

   assign mem_req = (state != IDLE);

   // Acks go back to the granted channel only
   assign wr.ack       = (state == WRITE_GNT) & mem_ack;
   assign refill.ack   = (state == REFILL_GNT) & mem_ack;
   assign refill.rdata = mem_rdata;

endmodule

/* hw/cache_bus_pkg.sv */
package cache_bus_pkg;

   localparam int DATA_W     = 32;
   localparam int NBYTES     = DATA_W / 8;                   // Byte lanes per word
   localparam int CTRL_REG_W = 3;

   typedef logic [DATA_W-1:0]     data_t;
   typedef logic [NBYTES-1:0]     strb_t;                    // All zero means read
   typedef logic [CTRL_REG_W-1:0] ctrl_reg_t;

   // Controller register map
   localparam ctrl_reg_t REG_READ_HIT   = 3'd0;
   localparam ctrl_reg_t REG_READ_MISS  = 3'd1;
   localparam ctrl_reg_t REG_WRITE_HIT  = 3'd2;
   localparam ctrl_reg_t REG_WRITE_MISS = 3'd3;
   localparam ctrl_reg_t REG_STATUS     = 3'd4;              // Bit 0 empty, bit 1 full
   localparam ctrl_reg_t REG_INVALIDATE = 3'd7;              // Write bit 0 set to flush

endpackage

/* hw/cache_cfg_pkg.sv */
package cache_cfg_pkg;

   // Address geometry of the direct-mapped cache
   localparam int ADDR_W        = 16;                        // Processor word address
   localparam int INDEX_W       = 6;                         // 64 lines
   localparam int OFFSET_W      = 2;                         // 4 words per line
   localparam int TAG_W         = ADDR_W - INDEX_W - OFFSET_W;
   localparam int NLINES        = 1 << INDEX_W;
   localparam int LINE_WORDS    = 1 << OFFSET_W;

   localparam int WTBUF_DEPTH_W = 2;                         // Log2 of buffered writes
   localparam int WTBUF_DEPTH   = 1 << WTBUF_DEPTH_W;

   typedef logic [ADDR_W-1:0]         word_addr_t;
   typedef logic [TAG_W-1:0]          tag_t;
   typedef logic [INDEX_W-1:0]        index_t;
   typedef logic [OFFSET_W-1:0]       offset_t;
   typedef logic [TAG_W+INDEX_W-1:0]  line_addr_t;           // Tag above index

endpackage

/* hw/cache_control.sv */
module cache_control (
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     req,
   input  cache_bus_pkg::ctrl_reg_t sel,
   input  cache_bus_pkg::data_t     wdata,
   output cache_bus_pkg::data_t     rdata,
   output logic                     ack,
   input  logic                     read_hit,
   input  logic                     read_miss,
   input  logic                     write_hit,
   input  logic                     write_miss,
   input  logic                     wtbuf_empty,
   input  logic                     wtbuf_full,
   output logic                     invalidate
);
   import cache_bus_pkg::*;

   data_t      cnt [4];     // Read hit, read miss, write hit, write miss
   logic [3:0] event_in;

   assign event_in = {write_miss, write_hit, read_miss, read_hit};

   // Command is one cycle wide since every access acks at once
   assign invalidate = req & (sel == REG_INVALIDATE) & wdata[0];
   assign ack        = req;

   // Saturating counters, flushed along with the lines
   always_ff @(posedge clk) begin
      for (int i = 0; i < 4; i++) begin
         if (reset | invalidate) begin
            cnt[i] <= '0;
         end else if (event_in[i] && cnt[i] != '1) begin
            cnt[i] <= cnt[i] + 1'b1;
         end
      end
   end

   always_comb begin
      case (sel)
         REG_READ_HIT:   rdata = cnt[0];
         REG_READ_MISS:  rdata = cnt[1];
         REG_WRITE_HIT:  rdata = cnt[2];
         REG_WRITE_MISS: rdata = cnt[3];
         REG_STATUS:     rdata = {{(DATA_W-2){1'b0}}, wtbuf_full, wtbuf_empty};
         default:        rdata = '0;      // Invalidate and spare registers read zero
      endcase
   end

endmodule

/* hw/cache_front_end.sv */
module cache_front_end (
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      req,
   input  logic                      ctrl,
   input  cache_cfg_pkg::word_addr_t addr,
   input  cache_bus_pkg::data_t      wdata,
   input  cache_bus_pkg::strb_t      wstrb,
   output cache_bus_pkg::data_t      rdata,
   output logic                      ack,
   output logic                      mem_side_req,
   output cache_cfg_pkg::word_addr_t mem_side_addr,
   output cache_bus_pkg::data_t      mem_side_wdata,
   output cache_bus_pkg::strb_t      mem_side_wstrb,
   input  cache_bus_pkg::data_t      mem_side_rdata,
   input  logic                      mem_side_ack,
   output logic                      ctrl_req,
   output cache_bus_pkg::ctrl_reg_t  ctrl_sel,
   output cache_bus_pkg::data_t      ctrl_wdata,
   input  cache_bus_pkg::data_t      ctrl_rdata,
   input  logic                      ctrl_ack
);
   import cache_cfg_pkg::*;
   import cache_bus_pkg::*;

   logic       busy;      // Captured request still waits for its ack
   logic       capture;
   logic       ctrl_q;    // Captured request goes to the controller
   word_addr_t addr_q;
   data_t      wdata_q;
   strb_t      wstrb_q;

   // Accept when idle, or in the ack cycle of the previous request
   assign capture = req & (~busy | ack);

   always_ff @(posedge clk) begin
      if (reset) begin
         busy <= 1'b0;
      end else if (capture) begin
         busy <= 1'b1;
      end else if (ack) begin
         busy <= 1'b0;    // Target answered, nothing new
      end
   end

   always_ff @(posedge clk) begin
      if (capture) begin
         ctrl_q  <= ctrl;
         addr_q  <= addr;
         wdata_q <= wdata;
         wstrb_q <= wstrb;
      end
   end

   assign mem_side_req   = busy & ~ctrl_q;
   assign mem_side_addr  = addr_q;
   assign mem_side_wdata = wdata_q;
   assign mem_side_wstrb = wstrb_q;

   assign ctrl_req   = busy & ctrl_q;
   assign ctrl_sel   = addr_q[CTRL_REG_W-1:0];          // Low address bits pick the register
   assign ctrl_wdata = (|wstrb_q) ? wdata_q : '0;       // A read never carries a command

   // Only the addressed target ever acks
   assign ack   = mem_side_ack | ctrl_ack;
   assign rdata = ctrl_q ? ctrl_rdata : mem_side_rdata;

endmodule

/* hw/cache_ifc.sv */
// Write channel, buffer head towards the memory bus
interface cache_wr_if;
   import cache_cfg_pkg::*;
   import cache_bus_pkg::*;

   logic       req;     // Buffer holds at least one write
   word_addr_t addr;
   data_t      wdata;
   strb_t      wstrb;
   logic       ack;     // Bus accepted the head, pop it

   modport source (output req, addr, wdata, wstrb, input ack);
   modport sink   (input req, addr, wdata, wstrb, output ack);
endinterface

// Refill channel, one word of a line per transfer
interface cache_refill_if;
   import cache_cfg_pkg::*;
   import cache_bus_pkg::*;

   logic       req;
   line_addr_t line;    // Line being filled
   offset_t    offset;  // Word within the line
   data_t      rdata;   // Valid with ack
   logic       ack;

   modport source (output req, line, offset, input rdata, ack);
   modport sink   (input req, line, offset, output rdata, ack);
endinterface

/* hw/cache_memory.sv */
module cache_memory (
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      req,
   input  cache_cfg_pkg::word_addr_t addr,
   input  cache_bus_pkg::data_t      wdata,
   input  cache_bus_pkg::strb_t      wstrb,
   output cache_bus_pkg::data_t      rdata,
   output logic                      ack,
   input  logic                      invalidate,
   output logic                      read_hit,
   output logic                      read_miss,
   output logic                      write_hit,
   output logic                      write_miss,
   output logic                      wtbuf_empty,
   output logic                      wtbuf_full,
   cache_wr_if.source                wr,
   cache_refill_if.source            refill
);
   import cache_cfg_pkg::*;
   import cache_bus_pkg::*;

   typedef enum logic [1:0] {IDLE, WAIT_EMPTY, FETCH, DONE} state_t;

   state_t            state;
   logic [NLINES-1:0] valid;
   tag_t              tag_mem  [NLINES];
   data_t             data_mem [NLINES*LINE_WORDS];   // Indexed by {index, offset}

   tag_t    tag;
   index_t  index;
   offset_t offset;
   offset_t fill_cnt;     // Next word of the refill
   logic    hit;
   logic    is_write;
   logic    idle_req;
   logic    push;
   logic    last_fill;    // Final word of the line arrives
   data_t   merged;

   assign {tag, index, offset} = addr;

   assign hit      = valid[index] & (tag_mem[index] == tag);
   assign is_write = |wstrb;
   assign idle_req = req & (state == IDLE);
   assign push     = idle_req & is_write & ~wtbuf_full;   // Full buffer stalls the write

   // One strobe per request, taken in IDLE only
   assign write_hit  = push & hit;
   assign write_miss = push & ~hit;                      // No allocation on write
   assign read_hit   = idle_req & ~is_write & hit;
   assign read_miss  = idle_req & ~is_write & ~hit;

   assign ack   = push | read_hit | (state == DONE);
   assign rdata = data_mem[{index, offset}];              // Filled line in DONE

   assign refill.req    = (state == FETCH);
   assign refill.line   = {tag, index};
   assign refill.offset = fill_cnt;
   assign last_fill     = refill.req & refill.ack & (fill_cnt == '1);

   // Stored word with the strobed bytes replaced
   always_comb begin
      merged = data_mem[{index, offset}];
      for (int b = 0; b < NBYTES; b++) begin
         if (wstrb[b]) merged[8*b +: 8] = wdata[8*b +: 8];
      end
   end

   // Miss sequencing, drain the buffer first so memory is current
   always_ff @(posedge clk) begin
      if (reset) begin
         state    <= IDLE;
         fill_cnt <= '0;
      end else begin
         case (state)
            IDLE: begin
               if (read_miss) state <= WAIT_EMPTY;
            end
            WAIT_EMPTY: begin
               if (wtbuf_empty) state <= FETCH;
            end
            FETCH: begin
               if (refill.ack) begin
                  fill_cnt <= fill_cnt + 1'b1;              // Wraps to 0 after the last word
                  if (last_fill) state <= DONE;
               end
            end
            default: state <= IDLE;                         // DONE returns the word
         endcase
      end
   end

   // Invalidate wins over a line that completes the same cycle
   always_ff @(posedge clk) begin
      if (reset | invalidate) begin
         valid <= '0;
      end else if (last_fill) begin
         valid[index] <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (write_hit) data_mem[{index, offset}] <= merged;
      if (refill.req & refill.ack) data_mem[{index, fill_cnt}] <= refill.rdata;
      if (last_fill) tag_mem[index] <= tag;
   end

   // Every write goes through to memory
   cache_wtbuf wtbuf (
      .clk        (clk),
      .reset      (reset),
      .push       (push),
      .push_addr  (addr),
      .push_wdata (wdata),
      .push_wstrb (wstrb),
      .empty      (wtbuf_empty),
      .full       (wtbuf_full),
      .wr         (wr)
   );

endmodule

/* hw/cache_top.sv */
module cache_top (
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      req,
   input  logic                      ctrl,            // Controller access instead of cache
   input  cache_cfg_pkg::word_addr_t addr,
   input  cache_bus_pkg::data_t      wdata,
   input  cache_bus_pkg::strb_t      wstrb,
   output cache_bus_pkg::data_t      rdata,
   output logic                      ack,
   output logic                      mem_req,
   output cache_cfg_pkg::word_addr_t mem_addr,
   output cache_bus_pkg::data_t      mem_wdata,
   output cache_bus_pkg::strb_t      mem_wstrb,
   input  cache_bus_pkg::data_t      mem_rdata,
   input  logic                      mem_ack,
   input  logic                      invalidate_in,
   output logic                      invalidate_out,
   input  logic                      wtb_empty_in,    // Tie high without a next level
   output logic                      wtb_empty_out
);
   import cache_cfg_pkg::*;
   import cache_bus_pkg::*;

   logic       mem_side_req, mem_side_ack;
   word_addr_t mem_side_addr;
   data_t      mem_side_wdata, mem_side_rdata;
   strb_t      mem_side_wstrb;

   logic       ctrl_req, ctrl_ack, ctrl_invalidate;
   ctrl_reg_t  ctrl_sel;
   data_t      ctrl_wdata, ctrl_rdata;

   logic       read_hit, read_miss, write_hit, write_miss;
   logic       wtbuf_empty, wtbuf_full;

   cache_wr_if     wr_ch ();
   cache_refill_if refill_ch ();

   // Chain outputs for a next-level cache
   assign invalidate_out = ctrl_invalidate | invalidate_in;
   assign wtb_empty_out  = wtbuf_empty & wtb_empty_in;

   cache_front_end front_end (
      .clk            (clk),
      .reset          (reset),
      .req            (req),
      .ctrl           (ctrl),
      .addr           (addr),
      .wdata          (wdata),
      .wstrb          (wstrb),
      .rdata          (rdata),
      .ack            (ack),
      .mem_side_req   (mem_side_req),
      .mem_side_addr  (mem_side_addr),
      .mem_side_wdata (mem_side_wdata),
      .mem_side_wstrb (mem_side_wstrb),
      .mem_side_rdata (mem_side_rdata),
      .mem_side_ack   (mem_side_ack),
      .ctrl_req       (ctrl_req),
      .ctrl_sel       (ctrl_sel),
      .ctrl_wdata     (ctrl_wdata),
      .ctrl_rdata     (ctrl_rdata),
      .ctrl_ack       (ctrl_ack)
   );

   cache_memory cache_mem (
      .clk         (clk),
      .reset       (reset),
      .req         (mem_side_req),
      .addr        (mem_side_addr),
      .wdata       (mem_side_wdata),
      .wstrb       (mem_side_wstrb),
      .rdata       (mem_side_rdata),
      .ack         (mem_side_ack),
      .invalidate  (invalidate_out),      // Local command or upstream chain
      .read_hit    (read_hit),
      .read_miss   (read_miss),
      .write_hit   (write_hit),
      .write_miss  (write_miss),
      .wtbuf_empty (wtbuf_empty),
      .wtbuf_full  (wtbuf_full),
      .wr          (wr_ch.source),
      .refill      (refill_ch.source)
   );

   cache_back_end back_end (
      .clk       (clk),
      .reset     (reset),
      .wr        (wr_ch.sink),
      .refill    (refill_ch.sink),
      .mem_req   (mem_req),
      .mem_addr  (mem_addr),
      .mem_wdata (mem_wdata),
      .mem_wstrb (mem_wstrb),
      .mem_rdata (mem_rdata),
      .mem_ack   (mem_ack)
   );

   cache_control control (
      .clk         (clk),
      .reset       (reset),
      .req         (ctrl_req),
      .sel         (ctrl_sel),
      .wdata       (ctrl_wdata),
      .rdata       (ctrl_rdata),
      .ack         (ctrl_ack),
      .read_hit    (read_hit),
      .read_miss   (read_miss),
      .write_hit   (write_hit),
      .write_miss  (write_miss),
      .wtbuf_empty (wtbuf_empty),
      .wtbuf_full  (wtbuf_full),
      .invalidate  (ctrl_invalidate)
   );

endmodule

/* hw/cache_wtbuf.sv */
module cache_wtbuf (
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      push,
   input  cache_cfg_pkg::word_addr_t push_addr,
   input  cache_bus_pkg::data_t      push_wdata,
   input  cache_bus_pkg::strb_t      push_wstrb,
   output logic                      empty,
   output logic                      full,
   cache_wr_if.source                wr
);
   import cache_cfg_pkg::*;
   import cache_bus_pkg::*;

   word_addr_t addr_mem  [WTBUF_DEPTH];
   data_t      wdata_mem [WTBUF_DEPTH];
   strb_t      wstrb_mem [WTBUF_DEPTH];

   logic [WTBUF_DEPTH_W:0] wr_ptr;   // MSB tells full from empty
   logic [WTBUF_DEPTH_W:0] rd_ptr;
   logic                   do_push;
   logic                   pop;

   assign do_push = push & ~full;
   assign pop     = wr.req & wr.ack;  // Head written on the bus

   assign empty = (wr_ptr == rd_ptr);
   assign full  = (wr_ptr == {~rd_ptr[WTBUF_DEPTH_W], rd_ptr[WTBUF_DEPTH_W-1:0]});

   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (do_push) wr_ptr <= wr_ptr + 1'b1;
         if (pop)     rd_ptr <= rd_ptr + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (do_push) begin
         addr_mem[wr_ptr[WTBUF_DEPTH_W-1:0]]  <= push_addr;
         wdata_mem[wr_ptr[WTBUF_DEPTH_W-1:0]] <= push_wdata;
         wstrb_mem[wr_ptr[WTBUF_DEPTH_W-1:0]] <= push_wstrb;
      end
   end

   // Head of the queue, seen a cycle after its push
   assign wr.req   = ~empty;
   assign wr.addr  = addr_mem[rd_ptr[WTBUF_DEPTH_W-1:0]];
   assign wr.wdata = wdata_mem[rd_ptr[WTBUF_DEPTH_W-1:0]];
   assign wr.wstrb = wstrb_mem[rd_ptr[WTBUF_DEPTH_W-1:0]];

endmodule

/* sim.f */
hw/cache_cfg_pkg.sv
hw/cache_bus_pkg.sv
hw/cache_ifc.sv
hw/cache_wtbuf.sv
hw/cache_front_end.sv
hw/cache_memory.sv
hw/cache_back_end.sv
hw/cache_control.sv
hw/cache_top.sv
verif/cache_assertions.sv
verif/cache_tb.sv

/* verif/cache_assertions.sv */
module cache_assertions (
   input logic                      clk,
   input logic                      reset,
   input logic                      ack,
   input logic                      mem_req,
   input logic                      mem_ack,
   input cache_cfg_pkg::word_addr_t mem_addr,
   input cache_bus_pkg::data_t      mem_wdata,
   input cache_bus_pkg::strb_t      mem_wstrb
);

   // Bus request and its fields hold until mem_ack, write data only on writes
   property bus_held;
      @(posedge clk) disable iff (reset)
         mem_req && !mem_ack |=> mem_req && $stable(mem_addr) && $stable(mem_wstrb)
                                 && (mem_wstrb == '0 || $stable(mem_wdata));
   endproperty

   assert property (bus_held) else $error("mem_req or its fields changed before mem_ack");

   assert property (@(posedge clk) disable iff (reset) ack |=> !ack)
      else $error("ack high for two cycles in a row");

   // Quiet ports straight out of reset
   assert property (@(posedge clk) reset |=> !ack && !mem_req)
      else $error("ack or mem_req high right after reset");

endmodule

bind cache_top cache_assertions assertions (
   .clk       (clk),
   .reset     (reset),
   .ack       (ack),
   .mem_req   (mem_req),
   .mem_ack   (mem_ack),
   .mem_addr  (mem_addr),
   .mem_wdata (mem_wdata),
   .mem_wstrb (mem_wstrb)
);

/* verif/cache_tb.sv */
module cache_tb;
   import cache_cfg_pkg::*;
   import cache_bus_pkg::*;

   localparam int TIMEOUT = 200;          // Cycles allowed for any single wait

   logic       clk, reset;
   logic       req, ctrl, ack;
   word_addr_t addr;
   data_t      wdata, rdata;
   strb_t      wstrb;
   logic       mem_req, mem_ack;
   word_addr_t mem_addr;
   data_t      mem_wdata, mem_rdata;
   strb_t      mem_wstrb;
   logic       invalidate_in, invalidate_out;
   logic       wtb_empty_in, wtb_empty_out;

   data_t      mem_model [word_addr_t];   // Memory behind the bus
   data_t      ref_mem   [word_addr_t];   // Words as the processor wrote them
   word_addr_t bus_writes [$];            // Write addresses in bus order
   logic       mem_hold;                  // Memory never answers while set
   logic       inv_seen;                  // invalidate_out in the last ack cycle
   bit         passed;
   bit         fail_seen;

   cache_top DUT (.*);

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // Preload pattern, unique per address
   function automatic data_t init_word(word_addr_t a);
      return {a ^ 16'h9e37, a};
   endfunction

   function automatic data_t model_word(word_addr_t a);
      return mem_model.exists(a) ? mem_model[a] : init_word(a);
   endfunction

   function automatic data_t expected_word(word_addr_t a);
      return ref_mem.exists(a) ? ref_mem[a] : init_word(a);
   endfunction

   // Strobed bytes come from the new word
   function automatic data_t merge_bytes(data_t old, data_t wd, strb_t ws);
      data_t mask;
      mask = {{8{ws[3]}}, {8{ws[2]}}, {8{ws[1]}}, {8{ws[0]}}};
      return (old & ~mask) | (wd & mask);
   endfunction

   // Memory model, one transfer at a time with 0 to 3 wait cycles
   initial begin
      int unsigned delay;
      bit          counting;
      mem_ack   = 1'b0;
      mem_rdata = '0;
      delay     = 0;
      counting  = 1'b0;
      forever begin
         @(posedge clk);
         #1;
         if (mem_ack) begin
            mem_ack = 1'b0;                      // Back end is idle again
         end else if (mem_req && !mem_hold) begin
            if (!counting) begin
               counting = 1'b1;
               delay    = $urandom_range(3, 0);
            end
            if (delay == 0) begin
               counting = 1'b0;
               if (mem_wstrb != '0) begin
                  mem_model[mem_addr] = merge_bytes(model_word(mem_addr), mem_wdata, mem_wstrb);
                  bus_writes.push_back(mem_addr);
               end
               mem_rdata = model_word(mem_addr);
               mem_ack   = 1'b1;
            end else begin
               delay--;
            end
         end
      end
   end

   task automatic report_failure(input string why);
      $display("%s", why);
      fail_seen = 1'b1;
      $display("** FAIL **");
      $fatal(1, "Simulation stopped at the first error");
   endtask

   task automatic check_eq(input string name, input data_t actual, input data_t expected);
      if (actual !== expected)
         report_failure($sformatf("** Error: %s = 0x%h, expected 0x%h", name, actual, expected));
   endtask

   // One clock step of a wait loop, counted against its own limit
   task automatic step_cycle(inout int cycles, input string what);
      @(posedge clk);
      #1;
      cycles++;
      if (cycles > TIMEOUT)
         report_failure($sformatf("Timed out after %0d cycles waiting for %s", TIMEOUT, what));
   endtask

   // One processor request, held until ack
   task automatic access(input logic is_ctrl, input word_addr_t a, input data_t wd,
                         input strb_t ws, output data_t rd);
      int cycles;
      cycles = 0;
      ctrl   = is_ctrl;
      addr   = a;
      wdata  = wd;
      wstrb  = ws;
      req    = 1'b1;
      do begin
         step_cycle(cycles, "ack");
      end while (!ack);
      rd       = rdata;
      inv_seen = invalidate_out;
      req      = 1'b0;                       // Dropped inside the ack cycle
      @(posedge clk);                        // Idle cycle before the next request
      #1;
   endtask

   task automatic read_expect(input word_addr_t a, input string name);
      data_t rd;
      access(1'b0, a, '0, '0, rd);
      check_eq(name, rd, expected_word(a));
   endtask

   task automatic write_word(input word_addr_t a, input data_t wd, input strb_t ws);
      data_t rd;
      ref_mem[a] = merge_bytes(expected_word(a), wd, ws);
      access(1'b0, a, wd, ws, rd);
   endtask

   task automatic reg_expect(input ctrl_reg_t sel, input data_t value, input string name);
      data_t rd;
      access(1'b1, word_addr_t'(sel), '0, '0, rd);
      check_eq(name, rd, value);
   endtask

   // Invalidate command, also clears the counters
   task automatic flush_cache();
      data_t rd;
      access(1'b1, word_addr_t'(REG_INVALIDATE), 32'd1, 4'hf, rd);
   endtask

   task automatic wait_empty();
      int cycles;
      cycles = 0;
      while (!wtb_empty_out) step_cycle(cycles, "wtb_empty_out");
   endtask

   task automatic miss_then_hit();
      read_expect(16'h0124, "rdata on miss");
      read_expect(16'h0124, "rdata on hit");
      reg_expect(REG_READ_HIT, 32'd1, "read_hit count");
      reg_expect(REG_READ_MISS, 32'd1, "read_miss count");
   endtask

   task automatic write_then_read();
      flush_cache();
      read_expect(16'h2a36, "rdata before write");     // Brings the line in
      write_word(16'h2a36, 32'haabbccdd, 4'b0101);
      read_expect(16'h2a36, "rdata merged");
      wait_empty();
      check_eq("memory word", model_word(16'h2a36), expected_word(16'h2a36));
      reg_expect(REG_WRITE_HIT, 32'd1, "write_hit count");
   endtask

   task automatic write_miss_no_allocate();
      flush_cache();
      write_word(16'h3450, 32'h1234_5678, 4'hf);
      reg_expect(REG_WRITE_MISS, 32'd1, "write_miss count");
      read_expect(16'h3450, "rdata after write miss");  // Refill sees the drained write
      reg_expect(REG_READ_MISS, 32'd1, "read_miss count");
   endtask

   task automatic invalidate_lines();
      flush_cache();
      read_expect(16'h7718, "rdata first read");
      read_expect(16'h7718, "rdata cached");
      flush_cache();
      check_eq("invalidate_out on command", data_t'(inv_seen), 32'd1);
      read_expect(16'h7718, "rdata after command");
      reg_expect(REG_READ_MISS, 32'd1, "read_miss after command");
      invalidate_in = 1'b1;
      #1;
      check_eq("invalidate_out on chain", data_t'(invalidate_out), 32'd1);
      @(posedge clk);
      #1;
      invalidate_in = 1'b0;
      read_expect(16'h7718, "rdata after chain invalidate");
      reg_expect(REG_READ_MISS, 32'd2, "read_miss after chain");  // Chain keeps counters
      reg_expect(REG_READ_HIT, 32'd0, "read_hit after chain");
   endtask

   task automatic back_pressure();
      word_addr_t a;
      word_addr_t exp_order [$];
      int         cycles;
      flush_cache();
      bus_writes.delete();
      wtb_empty_in = 1'b0;
      mem_hold     = 1'b1;                       // First four writes pile up
      for (int i = 0; i < 8; i++) begin
         if (i == 4) begin
            reg_expect(REG_STATUS, 32'h2, "status while full");
            mem_hold = 1'b0;
         end
         a = word_addr_t'(16'h5600 + i);
         exp_order.push_back(a);
         write_word(a, $urandom, strb_t'($urandom_range(15, 1)));
      end
      cycles = 0;
      while (bus_writes.size() < 8) begin
         check_eq("wtb_empty_out while chain low", data_t'(wtb_empty_out), 32'd0);
         step_cycle(cycles, "the write drain");
      end
      for (int i = 0; i < 8; i++)
         check_eq("bus write address", data_t'(bus_writes[i]), data_t'(exp_order[i]));
      reg_expect(REG_STATUS, 32'h1, "status after drain");
      // Local buffer is empty now, the chain alone keeps the output low
      check_eq("wtb_empty_out with empty buffer", data_t'(wtb_empty_out), 32'd0);
      wtb_empty_in = 1'b1;
      wait_empty();
      foreach (exp_order[i]) read_expect(exp_order[i], "read back after burst");
   endtask

   initial begin
      void'($urandom(32'h558f));
      passed        = 1'b0;
      fail_seen     = 1'b0;
      reset         = 1'b1;
      req           = 1'b0;
      ctrl          = 1'b0;
      addr          = '0;
      wdata         = '0;
      wstrb         = '0;
      invalidate_in = 1'b0;
      wtb_empty_in  = 1'b1;                     // No next level behind this cache
      mem_hold      = 1'b0;
      repeat (3) @(posedge clk);
      #1;
      reset = 1'b0;
      miss_then_hit();
      write_then_read();
      write_miss_no_allocate();
      invalidate_lines();
      back_pressure();
      passed = 1'b1;
      $display("** PASS **");
      $finish;
   end

   // A run stopped from elsewhere, such as a failed assertion
   final begin
      if (!passed && !fail_seen) $display("** FAIL **");
   end

endmodule
